/* hw/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu (
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  rv_decode_if.alu      dec,
  output rv_pkg::word_t wb_data,
  output logic          br_taken
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  logic [4:0]    shamt;

  assign op_a  = dec.src_a_pc ? pc : rs1_data;
  assign op_b  = dec.src_b_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];  // Upper bits of a shift amount are ignored

  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:    wb_data = op_a + op_b;
      rv_pkg::ALU_SUB:    wb_data = op_a - op_b;
      rv_pkg::ALU_SLL:    wb_data = op_a << shamt;
      rv_pkg::ALU_SLT: begin
        wb_data = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      end
      rv_pkg::ALU_SLTU: begin
        wb_data = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
      end
      rv_pkg::ALU_XOR:    wb_data = op_a ^ op_b;
      rv_pkg::ALU_SRL:    wb_data = op_a >> shamt;
      rv_pkg::ALU_SRA:    wb_data = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:     wb_data = op_a | op_b;
      rv_pkg::ALU_AND:    wb_data = op_a & op_b;
      rv_pkg::ALU_PASS_B: wb_data = op_b;
      rv_pkg::ALU_LINK:   wb_data = pc + rv_pkg::INSN_BYTES;
      default:            wb_data = op_a + op_b;
    endcase
  end

  // Branch compare always works on the two register values
  always_comb begin
    case (dec.br_op)
      rv_pkg::BR_EQ:  br_taken = (rs1_data == rs2_data);
      rv_pkg::BR_NE:  br_taken = (rs1_data != rs2_data);
      rv_pkg::BR_LT:  br_taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::BR_GE:  br_taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::BR_LTU: br_taken = (rs1_data < rs2_data);
      rv_pkg::BR_GEU: br_taken = (rs1_data >= rs2_data);
      default:        br_taken = 1'b0;
    endcase
  end

endmodule

/* hw/rv_core_top.sv */
`timescale 1ns/100ps

module rv_core_top #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    insn,
  output rv_pkg::word_t    pc,
  output logic             halt,
  output logic             illegal,
  output logic             wb_en,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data
);

  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  logic          br_taken;

  rv_decode_if dec_bus ();

  rv_decoder decoder_i (
    .insn    (insn),
    .halt    (halt),
    .illegal (illegal),
    .dec     (dec_bus.decoder)
  );

  rv_reg_file reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec_bus.rf),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu alu_i (
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec      (dec_bus.alu),
    .wb_data  (wb_data),   // Also the register file write data
    .br_taken (br_taken)
  );

  rv_pc_unit #(
    .RESET_PC (RESET_PC)
  ) pc_unit_i (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec_bus.pc),
    .rs1_data (rs1_data),
    .br_taken (br_taken),
    .pc       (pc)
  );

  // Register file write port as seen from outside
  assign wb_en = dec_bus.rf_we;
  assign wb_rd = dec_bus.rd;

endmodule

/* hw/rv_decode_if.sv */
`timescale 1ns/100ps

interface rv_decode_if;

  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t    imm;        // Immediate of the current format
  rv_pkg::alu_op_e  alu_op;
  logic             src_a_pc;   // Operand A is pc instead of rs1
  logic             src_b_imm;  // Operand B is imm instead of rs2
  rv_pkg::br_op_e   br_op;
  rv_pkg::pc_sel_e  pc_sel;
  logic             rf_we;      // Already low for x0 and illegal words

  modport decoder (
    output rs1, rs2, rd, imm, alu_op, src_a_pc, src_b_imm, br_op, pc_sel, rf_we
  );

  modport alu (
    input imm, alu_op, src_a_pc, src_b_imm, br_op
  );

  modport pc (
    input imm, pc_sel
  );

  modport rf (
    input rs1, rs2, rd, rf_we
  );

endinterface

/* hw/rv_decoder.sv */
`timescale 1ns/100ps

module rv_decoder (
  input  rv_pkg::word_t insn,
  output logic          halt,
  output logic          illegal,
  rv_decode_if.decoder  dec
);

  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_j;
  rv_pkg::word_t   imm_u;
  logic            write_rd;
  logic            f7_ok;  // funct7 is 0 or the SUB/SRA pattern

  // Arithmetic op from funct3, alt selects SUB or SRA
  function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign f7_ok  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);

  assign dec.rs1 = insn[19:15];
  assign dec.rs2 = insn[24:20];
  assign dec.rd  = insn[11:7];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    dec.imm       = imm_i;
    dec.alu_op    = rv_pkg::ALU_ADD;
    dec.src_a_pc  = 1'b0;
    dec.src_b_imm = 1'b0;
    dec.br_op     = rv_pkg::BR_EQ;
    dec.pc_sel    = rv_pkg::PC_SEQ;  // Illegal words fall through to pc + 4
    write_rd      = 1'b0;
    halt          = 1'b0;
    illegal       = 1'b0;
    case (opcode)
      rv_pkg::OPC_LUI: begin
        dec.imm       = imm_u;
        dec.alu_op    = rv_pkg::ALU_PASS_B;
        dec.src_b_imm = 1'b1;
        write_rd      = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        dec.imm       = imm_u;
        dec.src_a_pc  = 1'b1;
        dec.src_b_imm = 1'b1;
        write_rd      = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        dec.imm    = imm_j;
        dec.alu_op = rv_pkg::ALU_LINK;
        dec.pc_sel = rv_pkg::PC_JAL;
        write_rd   = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        dec.alu_op = rv_pkg::ALU_LINK;  // Target is built in the PC unit
        dec.pc_sel = rv_pkg::PC_JALR;
        write_rd   = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        dec.imm = imm_b;
        case (funct3)
          3'b000:  dec.br_op = rv_pkg::BR_EQ;
          3'b001:  dec.br_op = rv_pkg::BR_NE;
          3'b100:  dec.br_op = rv_pkg::BR_LT;
          3'b101:  dec.br_op = rv_pkg::BR_GE;
          3'b110:  dec.br_op = rv_pkg::BR_LTU;
          3'b111:  dec.br_op = rv_pkg::BR_GEU;
          default: illegal = 1'b1;
        endcase
        if (!illegal) dec.pc_sel = rv_pkg::PC_BRANCH;
      end
      rv_pkg::OPC_OP_IMM: begin
        dec.alu_op    = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
        dec.src_b_imm = 1'b1;
        write_rd      = 1'b1;
        // Shift immediates only allow funct7 of 0, SRAI also 0100000
        if (funct3 == 3'b001 && funct7 != 7'b0000000) illegal = 1'b1;
        if (funct3 == 3'b101 && !f7_ok) illegal = 1'b1;
      end
      rv_pkg::OPC_OP: begin
        dec.alu_op = arith_op(funct3, funct7[5]);
        write_rd   = 1'b1;
        if (funct7 != 7'b0000000 &&
            !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          illegal = 1'b1;
        end
      end
      rv_pkg::OPC_MISC_MEM: ;  // FENCE has nothing to order here
      rv_pkg::OPC_SYSTEM: begin
        if (insn[31:7] == 25'd0) halt = 1'b1;  // ECALL
        else illegal = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

  assign dec.rf_we = write_rd && (dec.rd != 5'd0) && !illegal;

endmodule

/* hw/rv_pc_unit.sv */
`timescale 1ns/100ps

module rv_pc_unit #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst,
  rv_decode_if.pc       dec,
  input  rv_pkg::word_t rs1_data,
  input  logic          br_taken,
  output rv_pkg::word_t pc
);

  rv_pkg::word_t seq_pc;
  rv_pkg::word_t rel_pc;    // Target of branches and JAL
  rv_pkg::word_t jalr_sum;
  rv_pkg::word_t next_pc;

  assign seq_pc   = pc + rv_pkg::INSN_BYTES;
  assign rel_pc   = pc + dec.imm;
  assign jalr_sum = rs1_data + dec.imm;

  always_comb begin
    case (dec.pc_sel)
      rv_pkg::PC_SEQ:    next_pc = seq_pc;
      rv_pkg::PC_BRANCH: next_pc = br_taken ? rel_pc : seq_pc;
      rv_pkg::PC_JAL:    next_pc = rel_pc;
      rv_pkg::PC_JALR:   next_pc = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0};  // Clear bit 0
      default:           next_pc = seq_pc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

/* hw/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  localparam word_t INSN_BYTES = 32'd4;  // PC step per instruction

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,  // LUI
    ALU_LINK     // Return address pc + 4
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_op_e;

  typedef enum logic [1:0] {
    PC_SEQ,
    PC_BRANCH,
    PC_JAL,
    PC_JALR
  } pc_sel_e;

endpackage

/* hw/rv_reg_file.sv */
`timescale 1ns/100ps

module rv_reg_file (
  input  logic          clk,
  input  logic          rst,
  rv_decode_if.rf       dec,
  input  rv_pkg::word_t wb_data,
  output rv_pkg::word_t rs1_data,
  output rv_pkg::word_t rs2_data
);

  localparam int NUM_REGS = 32;

  // x0 has no storage
  rv_pkg::word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (dec.rf_we) begin
      regs[dec.rd] <= wb_data;  // rf_we is never high for rd of 0
    end
  end

  // Asynchronous reads
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (dec.rs1 != 5'd0) rs1_data = regs[dec.rs1];
    if (dec.rs2 != 5'd0) rs2_data = regs[dec.rs2];
  end

endmodule

/* tb/rv_core_sva.sv */
`timescale 1ns/100ps

module rv_core_sva #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input logic             clk,
  input logic             rst,
  input rv_pkg::word_t    pc,
  input logic             illegal,
  input logic             wb_en,
  input rv_pkg::reg_idx_t wb_rd
);

  int fail_count = 0;  // Number of assertion failures so far

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      $error("pc %h is not a multiple of 4", pc);
      fail_count++;
    end

  // x0 is never a write target
  no_x0_write: assert property (@(posedge clk) disable iff (rst) !(wb_en && wb_rd == 5'd0))
    else begin
      $error("write enabled with rd of x0");
      fail_count++;
    end

  no_illegal_write: assert property (@(posedge clk) disable iff (rst) !(illegal && wb_en))
    else begin
      $error("illegal instruction enables a register write");
      fail_count++;
    end

  reset_pc: assert property (@(posedge clk) rst |=> pc == RESET_PC)
    else begin
      $error("pc %h after reset, expected %h", pc, RESET_PC);
      fail_count++;
    end

endmodule

bind rv_core_top rv_core_sva #(.RESET_PC(RESET_PC)) sva_i (
  .clk     (clk),
  .rst     (rst),
  .pc      (pc),
  .illegal (illegal),
  .wb_en   (wb_en),
  .wb_rd   (wb_rd)
);

/* tb/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core;

  localparam int            PERIOD       = 20;
  localparam int            RESET_CYCLES = 5;
  localparam int            NUM_ENTRIES  = 39;
  localparam rv_pkg::word_t RESET_PC     = 32'h0000_0000;
  localparam rv_pkg::word_t NOP          = 32'h0000_0013;  // addi x0, x0, 0

  typedef struct packed {
    rv_pkg::word_t    insn;
    logic             wb_en;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::word_t    wb_data;
    logic             halt;
    logic             illegal;
    rv_pkg::word_t    next_pc;  // pc once this insn has retired
  } entry_t;

  logic             clk = 1'b0;
  logic             rst;
  rv_pkg::word_t    insn;
  rv_pkg::word_t    pc;
  logic             halt;
  logic             illegal;
  logic             wb_en;
  rv_pkg::reg_idx_t wb_rd;
  rv_pkg::word_t    wb_data;

  entry_t tbl [NUM_ENTRIES];
  int     n_fill = 0;
  int     errors = 0;
  int     n_pass = 0;
  int     n_fail = 0;

  rv_core_top #(.RESET_PC(RESET_PC)) dut_i (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .halt    (halt),
    .illegal (illegal),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  always #(PERIOD/2) clk = ~clk;

  task automatic add_entry(input rv_pkg::word_t i, input logic en, input rv_pkg::reg_idx_t rd,
                           input rv_pkg::word_t d, input logic h, input logic ill,
                           input rv_pkg::word_t nxt);
    tbl[n_fill] = '{i, en, rd, d, h, ill, nxt};
    n_fill++;
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t exp, input rv_pkg::word_t act);
    if (act !== exp) begin
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_idx(input string name, input rv_pkg::reg_idx_t exp,
                           input rv_pkg::reg_idx_t act);
    if (act !== exp) begin
      $display("mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic record_result(input string label, input int err_before);
    if (errors == err_before) begin
      n_pass++;
      $display("%s ok", label);
    end else begin
      n_fail++;
      $display("%s failed", label);
    end
  endtask

  // Register state so far is x1 = 5, x2 = -3 and x3 = 0x80000000
  task automatic fill_table();
    add_entry(32'h00500093, 1, 5'd1,  32'h0000_0005, 0, 0, 32'h04);  // addi x1, x0, 5
    add_entry(32'hFFD00113, 1, 5'd2,  32'hFFFF_FFFD, 0, 0, 32'h08);  // addi x2, x0, -3
    add_entry(32'h800001B7, 1, 5'd3,  32'h8000_0000, 0, 0, 32'h0C);  // lui x3, 0x80000
    add_entry(32'h00001217, 1, 5'd4,  32'h0000_100C, 0, 0, 32'h10);  // auipc x4, 1
    add_entry(32'h002082B3, 1, 5'd5,  32'h0000_0002, 0, 0, 32'h14);  // add x5, x1, x2
    add_entry(32'h40208333, 1, 5'd6,  32'h0000_0008, 0, 0, 32'h18);  // sub x6, x1, x2
    add_entry(32'h001093B3, 1, 5'd7,  32'h0000_00A0, 0, 0, 32'h1C);  // sll x7, x1, x1
    add_entry(32'h0011D433, 1, 5'd8,  32'h0400_0000, 0, 0, 32'h20);  // srl x8, x3, x1
    add_entry(32'h4011D4B3, 1, 5'd9,  32'hFC00_0000, 0, 0, 32'h24);  // sra x9, x3, x1
    add_entry(32'h0011A533, 1, 5'd10, 32'h0000_0001, 0, 0, 32'h28);  // slt x10, x3, x1
    add_entry(32'h0011B5B3, 1, 5'd11, 32'h0000_0000, 0, 0, 32'h2C);  // sltu x11, x3, x1
    add_entry(32'hFFF12613, 1, 5'd12, 32'h0000_0001, 0, 0, 32'h30);  // slti x12, x2, -1
    add_entry(32'hFFF0B693, 1, 5'd13, 32'h0000_0001, 0, 0, 32'h34);  // sltiu x13, x1, -1
    add_entry(32'h7FF14713, 1, 5'd14, 32'hFFFF_F802, 0, 0, 32'h38);  // xori x14, x2, 0x7ff
    add_entry(32'h0F00E793, 1, 5'd15, 32'h0000_00F5, 0, 0, 32'h3C);  // ori x15, x1, 0xf0
    add_entry(32'h0F017813, 1, 5'd16, 32'h0000_00F0, 0, 0, 32'h40);  // andi x16, x2, 0xf0
    add_entry(32'h00708013, 0, 5'd0,  32'h0,         0, 0, 32'h44);  // addi x0, x1, 7
    add_entry(32'h000088B3, 1, 5'd17, 32'h0000_0005, 0, 0, 32'h48);  // add x17, x1, x0
    // Branches in taken and not taken pairs with offset +8
    add_entry(32'h00108463, 0, 5'd0,  32'h0,         0, 0, 32'h50);  // beq x1, x1
    add_entry(32'h00208463, 0, 5'd0,  32'h0,         0, 0, 32'h54);
    add_entry(32'h00209463, 0, 5'd0,  32'h0,         0, 0, 32'h5C);  // bne x1, x2
    add_entry(32'h00109463, 0, 5'd0,  32'h0,         0, 0, 32'h60);
    add_entry(32'h00114463, 0, 5'd0,  32'h0,         0, 0, 32'h68);  // blt x2, x1
    add_entry(32'h0020C463, 0, 5'd0,  32'h0,         0, 0, 32'h6C);
    add_entry(32'h0020D463, 0, 5'd0,  32'h0,         0, 0, 32'h74);  // bge x1, x2
    add_entry(32'h00115463, 0, 5'd0,  32'h0,         0, 0, 32'h78);
    add_entry(32'h0020E463, 0, 5'd0,  32'h0,         0, 0, 32'h80);  // bltu x1, x2
    add_entry(32'h00116463, 0, 5'd0,  32'h0,         0, 0, 32'h84);
    add_entry(32'h00117463, 0, 5'd0,  32'h0,         0, 0, 32'h8C);  // bgeu x2, x1
    add_entry(32'h0020F463, 0, 5'd0,  32'h0,         0, 0, 32'h90);
    add_entry(32'hFE2098E3, 0, 5'd0,  32'h0,         0, 0, 32'h80);  // bne x1, x2, -16
    // Jumps where the jalr sum 0xa5 lands on 0xa4
    add_entry(32'h0100096F, 1, 5'd18, 32'h0000_0084, 0, 0, 32'h90);  // jal x18, +16
    add_entry(32'h0A0089E7, 1, 5'd19, 32'h0000_0094, 0, 0, 32'hA4);  // jalr x19, 0xa0(x1)
    add_entry(32'hFF9FF06F, 0, 5'd0,  32'h0,         0, 0, 32'h9C);  // jal x0, -8
    add_entry(32'h00000073, 0, 5'd0,  32'h0,         1, 0, 32'hA0);  // ecall
    add_entry(32'h0FF0000F, 0, 5'd0,  32'h0,         0, 0, 32'hA4);  // fence
    add_entry(32'h0000007F, 0, 5'd0,  32'h0,         0, 1, 32'hA8);  // Unknown opcode
    add_entry(32'h022080B3, 0, 5'd0,  32'h0,         0, 1, 32'hAC);  // funct7 of 1 (mul)
    add_entry(32'h00008A33, 1, 5'd20, 32'h0000_0005, 0, 0, 32'hB0);  // x1 kept its value
  endtask

  initial begin
    int err_before;
    rst  = 1'b1;
    insn = NOP;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    err_before = errors;
    check_word("pc", RESET_PC, pc);
    record_result("reset", err_before);
    for (int n = 0; n < NUM_ENTRIES; n++) begin
      err_before = errors;
      insn = tbl[n].insn;
      #(PERIOD/4);  // Combinational outputs settle well before the rising edge
      check_bit("halt", tbl[n].halt, halt);
      check_bit("illegal", tbl[n].illegal, illegal);
      check_bit("wb_en", tbl[n].wb_en, wb_en);
      if (tbl[n].wb_en) begin
        check_idx("wb_rd", tbl[n].wb_rd, wb_rd);
        check_word("wb_data", tbl[n].wb_data, wb_data);
      end
      @(posedge clk);
      #1;
      check_word("pc", tbl[n].next_pc, pc);
      record_result($sformatf("test %0d insn %h", n, tbl[n].insn), err_before);
      @(negedge clk);
    end
    $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
    if (errors == 0 && n_fail == 0 && dut_i.sva_i.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((NUM_ENTRIES + RESET_CYCLES + 10) * PERIOD);
    $display("run timed out before all tests finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* verilog.f */
hw/rv_pkg.sv
hw/rv_decode_if.sv
hw/rv_decoder.sv
hw/rv_reg_file.sv
hw/rv_alu.sv
hw/rv_pc_unit.sv
hw/rv_core_top.sv
tb/rv_core_sva.sv
tb/tb_rv_core.sv
